//--- Makefile
# Verilator build and run of the response subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_response_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
+incdir+tests
hw/resp_pkg.sv
hw/tag_table.sv
hw/response_control.sv
hw/error_collector.sv
hw/response_subsystem.sv
tests/tb_response_subsystem.sv

//--- hw/error_collector.sv
// Error collector: sticky error flag and saturating error count fed by
// response errors and unknown tags, cleared by the host

module error_collector import resp_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  resp_error_t response_error,
  input  logic        tag_unknown,
  input  logic        err_clear,
  output logic        error_sticky,
  output err_count_t  error_count
);

  logic        any_response_error;
  logic [1:0]  increment;
  logic [16:0] count_sum;

  assign any_response_error = |response_error;

  // Both sources count on their own, so a shared cycle adds two
  assign increment = {1'b0, any_response_error} + {1'b0, tag_unknown};

  // One extra bit to catch the wrap
  assign count_sum = {1'b0, error_count} + {15'd0, increment};

  //////////////////////////////////////////////////////////////////////
  // Sticky flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      error_sticky <= 1'b0;
    end else if (err_clear) begin
      error_sticky <= 1'b0;
    end else if (any_response_error || tag_unknown) begin
      error_sticky <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Saturating count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      error_count <= '0;
    end else if (err_clear) begin
      error_count <= '0;
    end else if (count_sum[16]) begin
      error_count <= '1;
    end else begin
      error_count <= count_sum[15:0];
    end
  end

endmodule

//--- hw/resp_pkg.sv
// Response path definitions shared by the tag table, response control
// and error collector: widths, command types, host codes and parity

package resp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Command tag as issued to the host
  typedef logic [7:0] tag_t;

  // Host response code
  typedef logic [7:0] resp_code_t;

  // Credits returned with a response, passed straight through
  typedef logic [8:0] credits_t;

  // Parity error on top, code errors below
  typedef logic [6:0] resp_error_t;

  typedef logic [15:0] err_count_t;

  // Kind of command held against a tag, cmd_none marks a free tag
  typedef enum logic [2:0] {
    cmd_none           = 3'd0,
    cmd_read           = 3'd1,
    cmd_write          = 3'd2,
    cmd_wed            = 3'd3,
    cmd_restart        = 3'd4,
    cmd_prefetch_read  = 3'd5,
    cmd_prefetch_write = 3'd6
  } cmd_type_t;

  //////////////////////////////////////////////////////////////////////
  // Host response codes
  //////////////////////////////////////////////////////////////////////

  localparam resp_code_t resp_done    = 8'h00;
  localparam resp_code_t resp_aerror  = 8'h01;
  localparam resp_code_t resp_derror  = 8'h03;
  localparam resp_code_t resp_nlock   = 8'h04;
  localparam resp_code_t resp_nres    = 8'h05;
  localparam resp_code_t resp_flushed = 8'h06;
  localparam resp_code_t resp_fault   = 8'h07;
  localparam resp_code_t resp_failed  = 8'h08;
  localparam resp_code_t resp_paged   = 8'h0A;

  // Bit positions inside resp_error_t
  localparam int err_bit_parity = 6;
  localparam int err_bit_aerror = 5;
  localparam int err_bit_derror = 4;
  localparam int err_bit_failed = 3;
  localparam int err_bit_fault  = 2;
  localparam int err_bit_nres   = 1;
  localparam int err_bit_paged  = 0;

  // Bit that gives tag plus parity an odd number of ones
  function automatic logic odd_parity(tag_t tag);
    return ~^tag;
  endfunction

endpackage

//--- hw/response_control.sv
// Response control: latches host responses, checks tag parity, classifies
// the response code and routes each response to one engine strobe

module response_control import resp_pkg::*; (
  input  logic        clock,
  input  logic        rstn,
  input  logic        enabled_in,
  input  logic        rsp_valid,
  input  tag_t        rsp_tag,
  input  logic        rsp_tag_parity,
  input  resp_code_t  rsp_code,
  input  credits_t    rsp_credits,
  input  cmd_type_t   lookup_type,
  output logic        read_response,
  output logic        write_response,
  output logic        wed_response,
  output logic        restart_response,
  output logic        prefetch_read_response,
  output logic        prefetch_write_response,
  output logic        out_valid,
  output tag_t        out_tag,
  output cmd_type_t   out_cmd_type,
  output resp_code_t  out_code,
  output credits_t    out_credits,
  output resp_error_t response_error
);

  logic       enabled;
  logic       in_valid;
  tag_t       in_tag;
  logic       in_tag_parity;
  resp_code_t in_code;
  credits_t   in_credits;

  // Routing stage, strobes ordered read down to prefetch write
  logic       route_valid;
  logic [5:0] route_strobes;
  tag_t       route_tag;
  cmd_type_t  route_cmd_type;
  resp_code_t route_code;
  credits_t   route_credits;

  logic        tag_parity_error;
  logic [5:0]  code_error;
  resp_error_t detected_errors;
  logic [5:0]  out_strobes;

  // Code errors, bit positions as in resp_error_t
  function automatic logic [5:0] classify_code(resp_code_t code);
    logic [5:0] bits;
    bits = '0;
    case (code)
      resp_aerror: bits[err_bit_aerror] = 1'b1;
      resp_derror: bits[err_bit_derror] = 1'b1;
      resp_failed: bits[err_bit_failed] = 1'b1;
      resp_fault:  bits[err_bit_fault]  = 1'b1;
      resp_nres:   bits[err_bit_nres]   = 1'b1;
      resp_paged:  bits[err_bit_paged]  = 1'b1;
      // Normal completions, retry cases and unnamed codes
      default:     bits = '0;
    endcase
    return bits;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Enable and input latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled       <= 1'b0;
      in_valid      <= 1'b0;
      in_tag        <= '0;
      in_tag_parity <= 1'b0;
      in_code       <= '0;
      in_credits    <= '0;
    end else begin
      enabled       <= enabled_in;
      in_valid      <= enabled && rsp_valid;
      in_tag        <= rsp_tag;
      in_tag_parity <= rsp_tag_parity;
      in_code       <= rsp_code;
      in_credits    <= rsp_credits;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Routing, lookup_type arrives with the latched response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      route_valid    <= 1'b0;
      route_strobes  <= '0;
      route_tag      <= '0;
      route_cmd_type <= cmd_none;
      route_code     <= '0;
      route_credits  <= '0;
    end else if (enabled && in_valid) begin
      case (lookup_type)
        cmd_read:           route_strobes <= 6'b100000;
        cmd_write:          route_strobes <= 6'b010000;
        cmd_wed:            route_strobes <= 6'b001000;
        cmd_restart:        route_strobes <= 6'b000100;
        cmd_prefetch_read:  route_strobes <= 6'b000010;
        cmd_prefetch_write: route_strobes <= 6'b000001;
        // Unknown tag, still reported but to no engine
        default:            route_strobes <= 6'b000000;
      endcase
      route_valid    <= 1'b1;
      route_tag      <= in_tag;
      route_cmd_type <= lookup_type;
      route_code     <= in_code;
      route_credits  <= in_credits;
    end else begin
      route_valid    <= 1'b0;
      route_strobes  <= '0;
      route_tag      <= '0;
      route_cmd_type <= cmd_none;
      route_code     <= '0;
      route_credits  <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_strobes  <= '0;
      out_valid    <= 1'b0;
      out_tag      <= '0;
      out_cmd_type <= cmd_none;
      out_code     <= '0;
      out_credits  <= '0;
    end else if (enabled) begin
      out_strobes  <= route_strobes;
      out_valid    <= route_valid;
      out_tag      <= route_tag;
      out_cmd_type <= route_cmd_type;
      out_code     <= route_code;
      out_credits  <= route_credits;
    end else begin
      out_strobes  <= '0;
      out_valid    <= 1'b0;
      out_tag      <= '0;
      out_cmd_type <= cmd_none;
      out_code     <= '0;
      out_credits  <= '0;
    end
  end

  assign read_response           = out_strobes[5];
  assign write_response          = out_strobes[4];
  assign wed_response            = out_strobes[3];
  assign restart_response        = out_strobes[2];
  assign prefetch_read_response  = out_strobes[1];
  assign prefetch_write_response = out_strobes[0];

  //////////////////////////////////////////////////////////////////////
  // Parity and code errors, one cycle behind the outputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_parity_error <= 1'b0;
      code_error       <= '0;
      detected_errors  <= '0;
      response_error   <= '0;
    end else begin
      if (in_valid) begin
        tag_parity_error <= odd_parity(in_tag) ^ in_tag_parity;
        code_error       <= classify_code(in_code);
      end else begin
        tag_parity_error <= 1'b0;
        code_error       <= '0;
      end
      detected_errors <= {tag_parity_error, code_error};
      response_error  <= detected_errors;
    end
  end

  // One engine at most, and only alongside a valid response
  assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(out_strobes) && (!(|out_strobes) || out_valid))
    else $error("engine strobes %b not one-hot or without out_valid", out_strobes);

endmodule

//--- hw/response_subsystem.sv
// Response subsystem top: tag table, response control and error
// collector wired between the host response port and the engines

module response_subsystem import resp_pkg::*; #(
  parameter int NUM_TAGS = 256
) (
  input  logic        clock,
  input  logic        rstn,
  input  logic        enabled_in,
  // Command issue
  input  logic        cmd_valid,
  input  tag_t        cmd_tag,
  input  cmd_type_t   cmd_type,
  // Host response
  input  logic        rsp_valid,
  input  tag_t        rsp_tag,
  input  logic        rsp_tag_parity,
  input  resp_code_t  rsp_code,
  input  credits_t    rsp_credits,
  input  logic        err_clear,
  // Engine strobes
  output logic        read_response,
  output logic        write_response,
  output logic        wed_response,
  output logic        restart_response,
  output logic        prefetch_read_response,
  output logic        prefetch_write_response,
  // Routed response
  output logic        out_valid,
  output tag_t        out_tag,
  output cmd_type_t   out_cmd_type,
  output resp_code_t  out_code,
  output credits_t    out_credits,
  // Error status
  output resp_error_t response_error,
  output logic        tag_unknown,
  output logic        error_sticky,
  output err_count_t  error_count
);

  cmd_type_t lookup_type;

  tag_table #(
    .NUM_TAGS(NUM_TAGS)
  ) i_tag_table (
    .clock       (clock),
    .rstn        (rstn),
    .cmd_valid   (cmd_valid),
    .cmd_tag     (cmd_tag),
    .cmd_type    (cmd_type),
    .rsp_valid   (rsp_valid),
    .rsp_tag     (rsp_tag),
    .lookup_type (lookup_type),
    .tag_unknown (tag_unknown)
  );

  response_control i_response_control (
    .clock                   (clock),
    .rstn                    (rstn),
    .enabled_in              (enabled_in),
    .rsp_valid               (rsp_valid),
    .rsp_tag                 (rsp_tag),
    .rsp_tag_parity          (rsp_tag_parity),
    .rsp_code                (rsp_code),
    .rsp_credits             (rsp_credits),
    .lookup_type             (lookup_type),
    .read_response           (read_response),
    .write_response          (write_response),
    .wed_response            (wed_response),
    .restart_response        (restart_response),
    .prefetch_read_response  (prefetch_read_response),
    .prefetch_write_response (prefetch_write_response),
    .out_valid               (out_valid),
    .out_tag                 (out_tag),
    .out_cmd_type            (out_cmd_type),
    .out_code                (out_code),
    .out_credits             (out_credits),
    .response_error          (response_error)
  );

  error_collector i_error_collector (
    .clock          (clock),
    .rstn           (rstn),
    .response_error (response_error),
    .tag_unknown    (tag_unknown),
    .err_clear      (err_clear),
    .error_sticky   (error_sticky),
    .error_count    (error_count)
  );

endmodule

//--- hw/tag_table.sv
// Tag table: holds the command type of every outstanding tag, returns it
// when the response comes back and frees the tag

module tag_table import resp_pkg::*; #(
  parameter int NUM_TAGS = 256
) (
  input  logic      clock,
  input  logic      rstn,
  input  logic      cmd_valid,
  input  tag_t      cmd_tag,
  input  cmd_type_t cmd_type,
  input  logic      rsp_valid,
  input  tag_t      rsp_tag,
  output cmd_type_t lookup_type,
  output logic      tag_unknown
);

  cmd_type_t entries [NUM_TAGS];

  logic rsp_in_range;
  logic cmd_in_range;
  logic rsp_free_entry;

  // Tags above NUM_TAGS never hold a command
  assign rsp_in_range = int'(rsp_tag) < NUM_TAGS;
  assign cmd_in_range = int'(cmd_tag) < NUM_TAGS;

  assign rsp_free_entry = !rsp_in_range || (entries[rsp_tag] == cmd_none);

  //////////////////////////////////////////////////////////////////////
  // Table update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < NUM_TAGS; i++) begin
        entries[i] <= cmd_none;
      end
    end else begin
      // Free first so a same-cycle issue to the tag overrides it
      if (rsp_valid && rsp_in_range) begin
        entries[rsp_tag] <= cmd_none;
      end
      if (cmd_valid && cmd_in_range) begin
        entries[cmd_tag] <= cmd_type;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup, lines up with the response latch downstream
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      lookup_type <= cmd_none;
      tag_unknown <= 1'b0;
    end else begin
      if (rsp_valid) begin
        lookup_type <= rsp_in_range ? entries[rsp_tag] : cmd_none;
        tag_unknown <= rsp_free_entry;
      end else begin
        lookup_type <= cmd_none;
        tag_unknown <= 1'b0;
      end
    end
  end

  // An issued tag must be free, or be freed by a response in the same cycle
  assert property (@(posedge clock) disable iff (!rstn)
    cmd_valid && cmd_in_range |->
      entries[cmd_tag] == cmd_none || (rsp_valid && rsp_tag == cmd_tag))
    else $error("command issued to tag %0d that is still in use", cmd_tag);

endmodule

//--- tests/tb_tasks.svh
// Checks, drive tasks, expected-value rules and directed tests for the
// response subsystem testbench

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
  end
endtask

//////////////////////////////////////////////////////////////////////
// Expected values
//////////////////////////////////////////////////////////////////////

// Tag plus this bit must hold an odd number of ones
function automatic logic expected_parity(tag_t tag);
  return ($countones(tag) % 2) == 0;
endfunction

function automatic resp_error_t expected_error(resp_code_t code, logic parity_bad);
  resp_error_t bits;
  bits = '0;
  bits[6] = parity_bad;
  case (code)
    resp_aerror: bits[5] = 1'b1;
    resp_derror: bits[4] = 1'b1;
    resp_failed: bits[3] = 1'b1;
    resp_fault:  bits[2] = 1'b1;
    resp_nres:   bits[1] = 1'b1;
    resp_paged:  bits[0] = 1'b1;
    default: ;
  endcase
  return bits;
endfunction

// Read, write, wed, restart, prefetch read, prefetch write
function automatic logic [5:0] expected_strobes(cmd_type_t kind);
  case (kind)
    cmd_read:           return 6'b100000;
    cmd_write:          return 6'b010000;
    cmd_wed:            return 6'b001000;
    cmd_restart:        return 6'b000100;
    cmd_prefetch_read:  return 6'b000010;
    cmd_prefetch_write: return 6'b000001;
    default:            return 6'b000000;
  endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Drive tasks
//////////////////////////////////////////////////////////////////////

task automatic issue_command(input tag_t tag, input cmd_type_t kind);
  @(posedge clock);
  cmd_valid <= 1'b1;
  cmd_tag   <= tag;
  cmd_type  <= kind;
  @(posedge clock);
  cmd_valid <= 1'b0;
endtask

// One response, then each stage checked on the cycle it is due
task automatic run_response(input tag_t tag, input cmd_type_t kind, input resp_code_t code,
                            input logic parity_bad, input logic unknown);
  credits_t    credits;
  resp_error_t exp_error;
  credits   = credits_t'($urandom);
  exp_error = expected_error(code, parity_bad);
  if (unknown) exp_count++;
  if (exp_error != '0) exp_count++;
  @(posedge clock);
  rsp_valid      <= 1'b1;
  rsp_tag        <= tag;
  rsp_tag_parity <= expected_parity(tag) ^ parity_bad;
  rsp_code       <= code;
  rsp_credits    <= credits;
  @(posedge clock);
  rsp_valid <= 1'b0;
  @(negedge clock);
  check_value("tag_unknown", 32'(tag_unknown), 32'(unknown));
  @(negedge clock);
  check_value("out_valid before routing", 32'(out_valid), 32'd0);
  @(negedge clock);
  check_value("out_valid", 32'(out_valid), 32'd1);
  check_value("engine strobes", 32'(strobes), 32'(expected_strobes(kind)));
  check_value("out_tag", 32'(out_tag), 32'(tag));
  check_value("out_cmd_type", 32'(out_cmd_type), 32'(kind));
  check_value("out_code", 32'(out_code), 32'(code));
  check_value("out_credits", 32'(out_credits), 32'(credits));
  @(negedge clock);
  check_value("response_error", 32'(response_error), 32'(exp_error));
  check_value("out_valid after one cycle", 32'(out_valid), 32'd0);
  @(negedge clock);
  check_value("error_count", 32'(error_count), exp_count);
  check_value("error_sticky", 32'(error_sticky), 32'(exp_count != 0));
endtask

//////////////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////////////

task automatic route_each_type();
  cmd_type_t kinds [6];
  tag_t      tag;
  kinds = '{cmd_read, cmd_write, cmd_wed, cmd_restart, cmd_prefetch_read,
            cmd_prefetch_write};
  foreach (kinds[i]) begin
    tag = tag_t'($urandom);
    issue_command(tag, kinds[i]);
    run_response(tag, kinds[i], resp_done, 1'b0, 1'b0);
  end
endtask

// Wrong parity bit, still routed
task automatic flag_bad_parity();
  tag_t tag;
  tag = tag_t'($urandom);
  issue_command(tag, cmd_write);
  run_response(tag, cmd_write, resp_done, 1'b1, 1'b0);
  tag = tag_t'($urandom);
  issue_command(tag, cmd_restart);
  run_response(tag, cmd_restart, resp_done, 1'b1, 1'b0);
endtask

task automatic classify_codes();
  resp_code_t codes [10];
  tag_t       tag;
  // 0x02 has no name and sets no bit
  codes = '{resp_done, resp_aerror, resp_derror, resp_nlock, resp_nres,
            resp_flushed, resp_fault, resp_failed, resp_paged, 8'h02};
  foreach (codes[i]) begin
    tag = tag_t'($urandom);
    issue_command(tag, cmd_read);
    run_response(tag, cmd_read, codes[i], 1'b0, 1'b0);
  end
endtask

task automatic reject_unknown_tag();
  tag_t tag;
  tag = tag_t'($urandom);
  issue_command(tag, cmd_write);
  run_response(tag, cmd_write, resp_done, 1'b0, 1'b0);
  // Second response to a freed tag
  run_response(tag, cmd_none, resp_done, 1'b0, 1'b1);
  issue_command(tag, cmd_wed);
  run_response(tag, cmd_wed, resp_done, 1'b0, 1'b0);
endtask

task automatic pipeline_back_to_back();
  tag_t      tags [3];
  cmd_type_t kinds [3];
  credits_t  credits [3];
  tag_t      base;
  base  = tag_t'($urandom);
  kinds = '{cmd_read, cmd_prefetch_write, cmd_wed};
  foreach (tags[i]) begin
    tags[i]    = base + tag_t'(i);
    credits[i] = credits_t'($urandom);
    issue_command(tags[i], kinds[i]);
  end
  foreach (tags[i]) begin
    @(posedge clock);
    rsp_valid      <= 1'b1;
    rsp_tag        <= tags[i];
    rsp_tag_parity <= expected_parity(tags[i]);
    rsp_code       <= resp_done;
    rsp_credits    <= credits[i];
  end
  @(posedge clock);
  rsp_valid <= 1'b0;
  // First output shows right after the edge that drops rsp_valid
  foreach (tags[i]) begin
    @(negedge clock);
    check_value("pipelined out_valid", 32'(out_valid), 32'd1);
    check_value("pipelined strobes", 32'(strobes), 32'(expected_strobes(kinds[i])));
    check_value("pipelined out_tag", 32'(out_tag), 32'(tags[i]));
    check_value("pipelined out_credits", 32'(out_credits), 32'(credits[i]));
  end
  @(negedge clock);
  check_value("out_valid after burst", 32'(out_valid), 32'd0);
  repeat (3) @(negedge clock);
  check_value("error_count after burst", 32'(error_count), exp_count);
endtask

task automatic drop_while_disabled();
  tag_t tag;
  tag = tag_t'($urandom);
  issue_command(tag, cmd_read);
  @(posedge clock);
  enabled_in <= 1'b0;
  repeat (2) @(posedge clock);
  rsp_valid      <= 1'b1;
  rsp_tag        <= tag;
  rsp_tag_parity <= ~expected_parity(tag);
  rsp_code       <= resp_aerror;
  rsp_credits    <= credits_t'($urandom);
  @(posedge clock);
  rsp_valid <= 1'b0;
  // Bad parity and an error code, neither may show up
  repeat (6) begin
    @(negedge clock);
    check_value("disabled out_valid", 32'(out_valid), 32'd0);
    check_value("disabled strobes", 32'(strobes), 32'd0);
    check_value("disabled response_error", 32'(response_error), 32'd0);
    check_value("disabled tag_unknown", 32'(tag_unknown), 32'd0);
  end
  @(posedge clock);
  enabled_in <= 1'b1;
  repeat (2) @(posedge clock);
  @(negedge clock);
  check_value("error_count after disable", 32'(error_count), exp_count);
endtask

task automatic clear_error_status();
  check_value("errors present before clear", 32'(error_count != 0), 32'd1);
  @(posedge clock);
  err_clear <= 1'b1;
  @(posedge clock);
  err_clear <= 1'b0;
  exp_count = 0;
  @(negedge clock);
  check_value("error_sticky after clear", 32'(error_sticky), 32'd0);
  check_value("error_count after clear", 32'(error_count), 32'd0);
endtask

`endif

//--- tests/tb_response_subsystem.sv
// Testbench for the response subsystem: directed tests of routing, parity,
// code errors, unknown tags, pipelining, enable and error clear

module tb_response_subsystem import resp_pkg::*; ();

  localparam int clock_period  = 4;
  localparam int reset_cycles  = 10;

  // Every response with its command issue takes about nine cycles
  localparam int response_runs   = 21;
  localparam int response_cycles = 9;
  localparam int other_cycles    = 60;
  localparam int margin_cycles   = 200;
  localparam int watchdog_cycles = reset_cycles + response_runs * response_cycles +
                                   other_cycles + margin_cycles;

  logic        clock;
  logic        rstn;
  logic        enabled_in;
  logic        cmd_valid;
  tag_t        cmd_tag;
  cmd_type_t   cmd_type;
  logic        rsp_valid;
  tag_t        rsp_tag;
  logic        rsp_tag_parity;
  resp_code_t  rsp_code;
  credits_t    rsp_credits;
  logic        err_clear;

  logic        read_response;
  logic        write_response;
  logic        wed_response;
  logic        restart_response;
  logic        prefetch_read_response;
  logic        prefetch_write_response;
  logic        out_valid;
  tag_t        out_tag;
  cmd_type_t   out_cmd_type;
  resp_code_t  out_code;
  credits_t    out_credits;
  resp_error_t response_error;
  logic        tag_unknown;
  logic        error_sticky;
  err_count_t  error_count;

  // Engine strobes in read to prefetch write order
  logic [5:0] strobes;

  int checks    = 0;
  int errors    = 0;
  int exp_count = 0;

  assign strobes = {read_response, write_response, wed_response, restart_response,
                    prefetch_read_response, prefetch_write_response};

  response_subsystem i_response_subsystem (.*);

  `include "tb_tasks.svh"

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    #(watchdog_cycles * clock_period);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(39));
    rstn           <= 1'b0;
    enabled_in     <= 1'b1;
    cmd_valid      <= 1'b0;
    cmd_tag        <= '0;
    cmd_type       <= cmd_none;
    rsp_valid      <= 1'b0;
    rsp_tag        <= '0;
    rsp_tag_parity <= 1'b0;
    rsp_code       <= '0;
    rsp_credits    <= '0;
    err_clear      <= 1'b0;
    repeat (reset_cycles) @(posedge clock);
    rstn <= 1'b1;
    // Let the enable register pick up enabled_in
    repeat (2) @(posedge clock);
    @(negedge clock);
    check_value("out_valid after reset", 32'(out_valid), 32'd0);
    check_value("error_sticky after reset", 32'(error_sticky), 32'd0);
    check_value("error_count after reset", 32'(error_count), 32'd0);

    route_each_type();
    flag_bad_parity();
    classify_codes();
    reject_unknown_tag();
    pipeline_back_to_back();
    drop_while_disabled();
    clear_error_status();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
